// ==== butterfly/butterfly_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fft_defs.svh"

module butterfly_unit #(
	parameter fft_pkg::twiddle_kind_e KIND = fft_pkg::TW_GENERAL
) (
	input wire clk,
	input wire reset,
	input wire recv_val,
	input wire send_rdy,
	input wire fft_pkg::sample_t ar,
	input wire fft_pkg::sample_t ai,
	input wire fft_pkg::sample_t br,
	input wire fft_pkg::sample_t bi,
	input wire fft_pkg::sample_t wr,
	input wire fft_pkg::sample_t wi,
	output logic recv_rdy,
	output logic send_val,
	output fft_pkg::sample_t cr,
	output fft_pkg::sample_t ci,
	output fft_pkg::sample_t dr,
	output fft_pkg::sample_t di
);

	generate
		if (KIND == fft_pkg::TW_GENERAL) begin : g_general
			fft_pkg::sample_t ar_q;
			fft_pkg::sample_t ai_q;
			fft_pkg::sample_t tr;
			fft_pkg::sample_t ti;

			cmplx_mult cmult_i (
				.clk(clk),
				.reset(reset),
				.recv_val(recv_val),
				.send_rdy(send_rdy),
				.br(br),
				.bi(bi),
				.wr(wr),
				.wi(wi),
				.recv_rdy(recv_rdy),
				.send_val(send_val),
				.tr(tr),
				.ti(ti)
			);

			// a waits here while the product is formed
			always_ff @(posedge clk) begin
				if (recv_val && recv_rdy) begin
					ar_q <= ar;
					ai_q <= ai;
				end
			end

			assign cr = ar_q + tr;
			assign ci = ai_q + ti;
			assign dr = ar_q - tr;
			assign di = ai_q - ti;
		end else begin : g_trivial
			fft_pkg::sample_t tr;
			fft_pkg::sample_t ti;

			always_comb begin
				case (KIND)
					fft_pkg::TW_NEG_ONE: begin
						tr = -br;
						ti = -bi;
					end
					fft_pkg::TW_NEG_J: begin
						tr = bi;
						ti = -br;
					end
					fft_pkg::TW_POS_J: begin
						tr = -bi;
						ti = br;
					end
					default: begin
						tr = br;
						ti = bi;
					end
				endcase
			end

			always_ff @(posedge clk) begin
				if (recv_val && recv_rdy) begin
					cr <= ar + tr;
					ci <= ai + ti;
					dr <= ar - tr;
					di <= ai - ti;
				end
			end

			always_ff @(posedge clk) begin
				if (reset)
					send_val <= 1'b0;
				else if (recv_val && recv_rdy)
					send_val <= 1'b1;
				else if (send_rdy)
					send_val <= 1'b0;
			end

			assign recv_rdy = !send_val;
		end
	endgenerate

	hold_under_backpressure: assert property (@(posedge clk) disable iff (reset)
		send_val && !send_rdy |=> send_val && $stable({cr, ci, dr, di}));

endmodule

`default_nettype wire

// ==== butterfly/cmplx_mult.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fft_defs.svh"

module cmplx_mult (
	input wire clk,
	input wire reset,
	input wire recv_val,
	input wire send_rdy,
	input wire fft_pkg::sample_t br,
	input wire fft_pkg::sample_t bi,
	input wire fft_pkg::sample_t wr,
	input wire fft_pkg::sample_t wi,
	output logic recv_rdy,
	output logic send_val,
	output fft_pkg::sample_t tr,
	output fft_pkg::sample_t ti
);
	fft_pkg::cmult_state_e state;
	fft_pkg::cmult_state_e next_state;
	fft_pkg::sample_t br_q;
	fft_pkg::sample_t bi_q;
	fft_pkg::sample_t wr_q;
	fft_pkg::sample_t wi_q;
	fft_pkg::sample_t mul_a;
	fft_pkg::sample_t mul_b;
	fft_pkg::sample_t mul_p;
	fft_pkg::sample_t p_sum;
	fft_pkg::sample_t p_real;
	fft_pkg::sample_t p_imag;
	logic computing;
	logic mul_start;
	logic mul_busy;
	logic mul_done;

	always_comb begin
		next_state = state;
		case (state)
			fft_pkg::CM_IDLE: if (recv_val) next_state = fft_pkg::CM_SUM;
			fft_pkg::CM_SUM: if (mul_done) next_state = fft_pkg::CM_REAL;
			fft_pkg::CM_REAL: if (mul_done) next_state = fft_pkg::CM_IMAG;
			fft_pkg::CM_IMAG: if (mul_done) next_state = fft_pkg::CM_DONE;
			fft_pkg::CM_DONE: if (send_rdy) next_state = fft_pkg::CM_IDLE;
			default: next_state = fft_pkg::CM_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= fft_pkg::CM_IDLE;
		else
			state <= next_state;
	end

	always_ff @(posedge clk) begin
		if (state == fft_pkg::CM_IDLE && recv_val) begin
			br_q <= br;
			bi_q <= bi;
			wr_q <= wr;
			wi_q <= wi;
		end
	end

	always_comb begin
		case (state)
			fft_pkg::CM_SUM: begin
				mul_a = br_q + bi_q;
				mul_b = wr_q + wi_q;
			end
			fft_pkg::CM_IMAG: begin
				mul_a = bi_q;
				mul_b = wi_q;
			end
			default: begin
				mul_a = br_q;
				mul_b = wr_q;
			end
		endcase
	end

	assign computing = (state == fft_pkg::CM_SUM) || (state == fft_pkg::CM_REAL) ||
		(state == fft_pkg::CM_IMAG);
	// Launch once the multiplier is back in idle
	assign mul_start = computing && !mul_busy;

	fx_mult mult_i (
		.clk(clk),
		.reset(reset),
		.start(mul_start),
		.a(mul_a),
		.b(mul_b),
		.ack(1'b1),
		.busy(mul_busy),
		.done(mul_done),
		.product(mul_p)
	);

	always_ff @(posedge clk) begin
		if (mul_done) begin
			case (state)
				fft_pkg::CM_SUM: p_sum <= mul_p;
				fft_pkg::CM_REAL: p_real <= mul_p;
				fft_pkg::CM_IMAG: p_imag <= mul_p;
				default: p_sum <= p_sum;
			endcase
		end
	end

	assign tr = p_real - p_imag;
	assign ti = p_sum - p_real - p_imag;

	assign recv_rdy = (state == fft_pkg::CM_IDLE);
	assign send_val = (state == fft_pkg::CM_DONE);

	// Every product lands in a state that stores it
	done_only_while_computing: assert property (@(posedge clk) disable iff (reset)
		mul_done |-> computing);

endmodule

`default_nettype wire

// ==== butterfly/fx_mult.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fft_defs.svh"

module fx_mult (
	input wire clk,
	input wire reset,
	input wire start,
	input wire fft_pkg::sample_t a,
	input wire fft_pkg::sample_t b,
	input wire ack,
	output logic busy,
	output logic done,
	output fft_pkg::sample_t product
);
	localparam int W = `FFT_BIT_WIDTH;
	localparam int D = `FFT_DECIMAL_PT;
	localparam int ACC_W = W + D;
	localparam int SW = $clog2(W);
	localparam logic [SW-1:0] LAST = SW'(W - 1);

	fft_pkg::mult_state_e state;
	fft_pkg::mult_state_e next_state;
	logic [SW-1:0] step;
	logic last_step;
	logic [ACC_W-1:0] mcand;
	logic [W-1:0] mplier;
	logic [ACC_W-1:0] acc;
	logic [ACC_W-1:0] addend;

	always_comb begin
		next_state = state;
		case (state)
			fft_pkg::MUL_IDLE: if (start) next_state = fft_pkg::MUL_CALC;
			fft_pkg::MUL_CALC: if (last_step) next_state = fft_pkg::MUL_DONE;
			fft_pkg::MUL_DONE: if (ack) next_state = fft_pkg::MUL_IDLE;
			default: next_state = fft_pkg::MUL_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= fft_pkg::MUL_IDLE;
		else
			state <= next_state;
	end

	always_ff @(posedge clk) begin
		if (reset || state != fft_pkg::MUL_CALC)
			step <= '0;
		else
			step <= step + 1'b1;
	end

	assign last_step = (state == fft_pkg::MUL_CALC) && (step == LAST);

	// Sign bit of the multiplier carries weight -2^(W-1)
	assign addend = last_step ? -mcand : mcand;

	always_ff @(posedge clk) begin
		if (state == fft_pkg::MUL_IDLE && start) begin
			mcand <= {{D{a[W-1]}}, a};
			mplier <= b;
			acc <= '0;
		end else if (state == fft_pkg::MUL_CALC) begin
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
			if (mplier[0])
				acc <= acc + addend;
		end
	end

	// Dropping the low D bits floors the exact product
	assign product = acc[ACC_W-1:D];

	assign busy = (state != fft_pkg::MUL_IDLE);
	assign done = (state == fft_pkg::MUL_DONE);

	// Start to done takes W + 1 cycles
	done_after_full_calc: assert property (@(posedge clk) disable iff (reset)
		$rose(done) |-> $past(state == fft_pkg::MUL_IDLE && start, W + 1));

endmodule

`default_nettype wire

// ==== common/fft_defs.svh ====
`ifndef FFT_DEFS_SVH
`define FFT_DEFS_SVH

// Sample word width, two's complement
`define FFT_BIT_WIDTH 16

// Fractional bits, a value v stands for v/256
`define FFT_DECIMAL_PT 8

// Points in the transform
`define FFT_N_SAMPLES 8

`endif

// ==== common/fft_pkg.sv ====
`default_nettype none
`include "fft_defs.svh"

package fft_pkg;

	typedef logic signed [`FFT_BIT_WIDTH-1:0] sample_t;

	// Twiddle classes, all but TW_GENERAL avoid the multiplier
	typedef enum logic [2:0] {
		TW_GENERAL,
		TW_ONE,
		TW_NEG_ONE,
		TW_NEG_J,
		TW_POS_J
	} twiddle_kind_e;

	typedef enum logic [1:0] {
		MUL_IDLE,
		MUL_CALC,
		MUL_DONE
	} mult_state_e;

	// Products run in the order sum, real, imaginary
	typedef enum logic [2:0] {
		CM_IDLE,
		CM_SUM,
		CM_REAL,
		CM_IMAG,
		CM_DONE
	} cmult_state_e;

endpackage

`default_nettype wire

// ==== fft_stage.f ====
+incdir+common
common/fft_pkg.sv
butterfly/fx_mult.sv
butterfly/cmplx_mult.sv
butterfly/butterfly_unit.sv
src/fft_stage.sv
test/fft_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fft_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f fft_stage.f \
	--top-module fft_stage_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vfft_stage_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
	exit 1
fi
exit 0

// ==== src/fft_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fft_defs.svh"

module fft_stage #(
	parameter int STAGE = 2
) (
	input wire clk,
	input wire reset,
	input wire fft_pkg::sample_t recv_real [`FFT_N_SAMPLES],
	input wire fft_pkg::sample_t recv_imag [`FFT_N_SAMPLES],
	input wire recv_val,
	output logic recv_rdy,
	input wire fft_pkg::sample_t sine_table [`FFT_N_SAMPLES],
	output fft_pkg::sample_t send_real [`FFT_N_SAMPLES],
	output fft_pkg::sample_t send_imag [`FFT_N_SAMPLES],
	output logic send_val,
	input wire send_rdy
);
	localparam int N = `FFT_N_SAMPLES;
	localparam int NB = N / 2;
	localparam int SPAN = 1 << STAGE;

	logic [NB-1:0] bf_rdy;
	logic [NB-1:0] bf_val;
	logic drain_rdy;

	function automatic fft_pkg::twiddle_kind_e kind_of(input int k);
		if (k == 0)
			return fft_pkg::TW_ONE;
		else if (k == N / 2)
			return fft_pkg::TW_NEG_ONE;
		else if (k == N / 4)
			return fft_pkg::TW_NEG_J;
		else if (k == 3 * N / 4)
			return fft_pkg::TW_POS_J;
		return fft_pkg::TW_GENERAL;
	endfunction

	// Early finishers hold until every butterfly is done
	assign drain_rdy = send_rdy && send_val;

	generate
		for (genvar b = 0; b < NB; b++) begin : g_bf
			localparam int M = b % SPAN;
			localparam int G = b / SPAN;
			localparam int P = G * 2 * SPAN + M;
			localparam int Q = P + SPAN;
			localparam int K = M * N / (2 * SPAN);

			// W = cos - j*sin, cosine read a quarter turn ahead
			fft_pkg::sample_t w_imag;
			assign w_imag = -sine_table[K];

			butterfly_unit #(
				.KIND(kind_of(K))
			) bf_i (
				.clk(clk),
				.reset(reset),
				.recv_val(recv_val),
				.send_rdy(drain_rdy),
				.ar(recv_real[P]),
				.ai(recv_imag[P]),
				.br(recv_real[Q]),
				.bi(recv_imag[Q]),
				.wr(sine_table[(K + N / 4) % N]),
				.wi(w_imag),
				.recv_rdy(bf_rdy[b]),
				.send_val(bf_val[b]),
				.cr(send_real[P]),
				.ci(send_imag[P]),
				.dr(send_real[Q]),
				.di(send_imag[Q])
			);
		end
	endgenerate

	assign recv_rdy = &bf_rdy;
	assign send_val = &bf_val;

endmodule

`default_nettype wire

// ==== test/fft_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fft_defs.svh"

module fft_stage_tb;
	localparam int N = `FFT_N_SAMPLES;
	localparam int STAGE = 2;
	localparam int TIMEOUT = 200;

	logic clk;
	logic reset;
	logic recv_val;
	logic recv_rdy;
	logic send_val;
	logic send_rdy;
	fft_pkg::sample_t recv_real [N];
	fft_pkg::sample_t recv_imag [N];
	fft_pkg::sample_t sine_table [N];
	fft_pkg::sample_t send_real [N];
	fft_pkg::sample_t send_imag [N];

	fft_pkg::sample_t stim_real [N];
	fft_pkg::sample_t stim_imag [N];
	fft_pkg::sample_t exp_real [N];
	fft_pkg::sample_t exp_imag [N];
	fft_pkg::sample_t held_real [N];
	fft_pkg::sample_t held_imag [N];
	integer seed;
	int errors;

	fft_stage #(
		.STAGE(STAGE)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.recv_real(recv_real),
		.recv_imag(recv_imag),
		.recv_val(recv_val),
		.recv_rdy(recv_rdy),
		.sine_table(sine_table),
		.send_real(send_real),
		.send_imag(send_imag),
		.send_val(send_val),
		.send_rdy(send_rdy)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Exact product scaled by 2^-8, floored, then cut to the sample width
	function automatic fft_pkg::sample_t fmul(input fft_pkg::sample_t x,
			input fft_pkg::sample_t y);
		logic signed [31:0] full;
		full = 32'(x) * 32'(y);
		return fft_pkg::sample_t'(full >>> `FFT_DECIMAL_PT);
	endfunction

	function automatic void model_stage();
		int span;
		int m;
		int p;
		int q;
		int k;
		fft_pkg::sample_t wr;
		fft_pkg::sample_t wi;
		fft_pkg::sample_t tr;
		fft_pkg::sample_t ti;
		fft_pkg::sample_t b_sum;
		fft_pkg::sample_t w_sum;
		fft_pkg::sample_t pr;
		fft_pkg::sample_t pi;
		span = 1 << STAGE;
		for (int bf = 0; bf < N / 2; bf++) begin
			m = bf % span;
			p = (bf / span) * 2 * span + m;
			q = p + span;
			k = m * N / (2 * span);
			wr = sine_table[(k + 2) % N];
			wi = -sine_table[k];
			case (k)
				0: begin
					tr = stim_real[q];
					ti = stim_imag[q];
				end
				4: begin
					tr = -stim_real[q];
					ti = -stim_imag[q];
				end
				2: begin
					tr = stim_imag[q];
					ti = -stim_real[q];
				end
				6: begin
					tr = -stim_imag[q];
					ti = stim_real[q];
				end
				default: begin
					b_sum = stim_real[q] + stim_imag[q];
					w_sum = wr + wi;
					pr = fmul(stim_real[q], wr);
					pi = fmul(stim_imag[q], wi);
					tr = pr - pi;
					ti = fmul(b_sum, w_sum) - pr - pi;
				end
			endcase
			exp_real[p] = stim_real[p] + tr;
			exp_imag[p] = stim_imag[p] + ti;
			exp_real[q] = stim_real[p] - tr;
			exp_imag[q] = stim_imag[p] - ti;
		end
	endfunction

	task automatic check_sample(input string name, input fft_pkg::sample_t expected,
			input fft_pkg::sample_t actual);
		if (expected !== actual) begin
			$display("mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (expected !== actual) begin
			$display("mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_outputs();
		for (int i = 0; i < N; i++) begin
			check_sample($sformatf("send_real[%0d]", i), exp_real[i], send_real[i]);
			check_sample($sformatf("send_imag[%0d]", i), exp_imag[i], send_imag[i]);
		end
	endtask

	task automatic wait_recv_rdy(output bit ok);
		int cycles;
		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < TIMEOUT) begin
			@(negedge clk);
			ok = recv_rdy;
			cycles++;
		end
		if (!ok) begin
			$display("error at %0t: recv_rdy stayed low for %0d cycles", $time, TIMEOUT);
			errors++;
		end
	endtask

	task automatic wait_send_val(input logic level, output bit ok);
		int cycles;
		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < TIMEOUT) begin
			@(negedge clk);
			ok = (send_val === level);
			cycles++;
		end
		if (!ok) begin
			$display("error at %0t: send_val did not go to %b within %0d cycles",
				$time, level, TIMEOUT);
			errors++;
		end
	endtask

	// Offers the stimulus frame and returns after the accept edge
	task automatic drive_frame(output bit ok);
		@(posedge clk);
		for (int i = 0; i < N; i++) begin
			recv_real[i] <= stim_real[i];
			recv_imag[i] <= stim_imag[i];
		end
		recv_val <= 1'b1;
		wait_recv_rdy(ok);
		@(posedge clk);
		recv_val <= 1'b0;
	endtask

	task automatic run_frame();
		bit ok;
		model_stage();
		drive_frame(ok);
		if (ok)
			wait_send_val(1'b1, ok);
		if (ok)
			check_outputs();
	endtask

	task automatic fill_random();
		for (int i = 0; i < N; i++) begin
			stim_real[i] = fft_pkg::sample_t'($random(seed));
			stim_imag[i] = fft_pkg::sample_t'($random(seed));
		end
	endtask

	task automatic reset_levels();
		@(negedge clk);
		check_bit("send_val", 1'b0, send_val);
		check_bit("recv_rdy", 1'b1, recv_rdy);
	endtask

	// Butterfly 0 has k = 0, butterfly 2 has k = 2
	task automatic trivial_twiddles();
		for (int i = 0; i < N; i++) begin
			stim_real[i] = '0;
			stim_imag[i] = '0;
		end
		stim_real[0] = 16'sd3;
		stim_imag[0] = 16'sd1;
		stim_real[4] = 16'sd5;
		stim_imag[4] = -16'sd2;
		stim_real[2] = 16'sd10;
		stim_imag[2] = 16'sd4;
		stim_real[6] = 16'sd2;
		stim_imag[6] = 16'sd7;
		run_frame();
		check_sample("send_real[0]", 16'sd8, send_real[0]);
		check_sample("send_imag[0]", -16'sd1, send_imag[0]);
		check_sample("send_real[4]", -16'sd2, send_real[4]);
		check_sample("send_imag[4]", 16'sd3, send_imag[4]);
		check_sample("send_real[2]", 16'sd17, send_real[2]);
		check_sample("send_imag[2]", 16'sd2, send_imag[2]);
		check_sample("send_real[6]", 16'sd3, send_real[6]);
		check_sample("send_imag[6]", 16'sd6, send_imag[6]);
	endtask

	task automatic random_frames();
		for (int n = 0; n < 4; n++) begin
			fill_random();
			run_frame();
		end
	endtask

	task automatic inputs_ignored_while_busy();
		bit ok;
		fill_random();
		model_stage();
		drive_frame(ok);
		for (int n = 0; n < 6; n++) begin
			@(posedge clk);
			for (int i = 0; i < N; i++) begin
				recv_real[i] <= fft_pkg::sample_t'($random(seed));
				recv_imag[i] <= fft_pkg::sample_t'($random(seed));
			end
			@(negedge clk);
			check_bit("recv_rdy", 1'b0, recv_rdy);
		end
		if (ok)
			wait_send_val(1'b1, ok);
		if (ok)
			check_outputs();
	endtask

	task automatic hold_under_backpressure();
		bit ok;
		@(posedge clk);
		send_rdy <= 1'b0;
		fill_random();
		model_stage();
		drive_frame(ok);
		if (ok)
			wait_send_val(1'b1, ok);
		if (ok) begin
			check_outputs();
			for (int i = 0; i < N; i++) begin
				held_real[i] = send_real[i];
				held_imag[i] = send_imag[i];
			end
			repeat (30) begin
				@(negedge clk);
				check_bit("send_val", 1'b1, send_val);
				check_bit("recv_rdy", 1'b0, recv_rdy);
				for (int i = 0; i < N; i++) begin
					check_sample($sformatf("send_real[%0d]", i), held_real[i], send_real[i]);
					check_sample($sformatf("send_imag[%0d]", i), held_imag[i], send_imag[i]);
				end
			end
		end
		@(posedge clk);
		send_rdy <= 1'b1;
		wait_send_val(1'b0, ok);
		if (ok)
			check_bit("recv_rdy", 1'b1, recv_rdy);
	endtask

	task automatic sums_wrap();
		for (int i = 0; i < N; i++) begin
			stim_real[i] = fft_pkg::sample_t'(32000 + i * 100);
			stim_imag[i] = fft_pkg::sample_t'(-32000 - i * 50);
		end
		run_frame();
		// 32000 + 32400 folds past the top of the range
		check_sample("send_real[0]", -16'sd1136, send_real[0]);
	endtask

	initial begin
		errors = 0;
		seed = 32'h1f11;
		reset = 1'b1;
		recv_val = 1'b0;
		send_rdy = 1'b1;
		for (int i = 0; i < N; i++) begin
			recv_real[i] = '0;
			recv_imag[i] = '0;
		end
		sine_table[0] = 16'sd0;
		sine_table[1] = 16'sd181;
		sine_table[2] = 16'sd256;
		sine_table[3] = 16'sd181;
		sine_table[4] = 16'sd0;
		sine_table[5] = -16'sd181;
		sine_table[6] = -16'sd256;
		sine_table[7] = -16'sd181;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		reset_levels();
		trivial_twiddles();
		random_frames();
		inputs_ignored_while_busy();
		hold_under_backpressure();
		sums_wrap();

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
